// File: hdl/rvExecPkg.sv
// RV32I execute stage shared definitions
// opcodes, selector codes, widths and the request/response/control structs

package rvExecPkg;

  localparam int xlen    = 32; // data width
  localparam int opcodeW = 7;

  localparam logic [xlen-1:0] pcStep = xlen'(4); // sequential pc increment

  typedef enum logic [opcodeW-1:0] {
    opCompute  = 7'b0110011,
    opICompute = 7'b0010011,
    opBranch   = 7'b1100011,
    opLoad     = 7'b0000011,
    opStore    = 7'b0100011,
    opJal      = 7'b1101111,
    opJalr     = 7'b1100111,
    opLui      = 7'b0110111,
    opAuipc    = 7'b0010111
  } opcodeE;

  typedef enum logic [2:0] {
    immNone = 3'b000,
    immI    = 3'b001,
    immS    = 3'b010,
    immB    = 3'b011,
    immU    = 3'b100,
    immJ    = 3'b101,
    immShI  = 3'b110 // shift amount only
  } immSelE;

  typedef enum logic [1:0] {
    wbAlu = 2'b00,
    wbMem = 2'b01,
    wbPc4 = 2'b10,
    wbImm = 2'b11
  } wbSelE;

  typedef enum logic [1:0] {
    sizeByte = 2'b00,
    sizeHalf = 2'b01,
    sizeWord = 2'b10
  } memSizeE;

  // same encoding as load funct3
  typedef enum logic [2:0] {
    ldByte  = 3'b000,
    ldHalf  = 3'b001,
    ldWord  = 3'b010,
    ldByteU = 3'b100,
    ldHalfU = 3'b101
  } loadTypeE;

  localparam logic srcAReg = 1'b0;
  localparam logic srcAPc  = 1'b1;
  localparam logic srcBReg = 1'b0;
  localparam logic srcBImm = 1'b1;

  typedef struct packed {
    immSelE   immSel;
    wbSelE    wbSel;
    logic     regWrite;
    logic     aluSrcA;  // register or pc
    logic     aluSrcB;  // register or immediate
    logic     memRead;
    logic     memWrite;
    memSizeE  memSize;
    loadTypeE loadType;
    logic     illegal;
  } ctrlT;

  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] rs2Val;
  } execReqT;

  typedef struct packed {
    logic [xlen-1:0] rdValue;
    logic            rdWrite;
    logic [xlen-1:0] nextPc;
    logic [xlen-1:0] memAddr;
    logic            memRead;
    logic            memWrite;
    memSizeE         memSize;
    loadTypeE        loadType;
    logic [xlen-1:0] storeData;
    logic            halt;
  } execRespT;

endpackage

// File: hdl/instDecoder.sv
// Instruction decoder
// maps the opcode to control signals and builds the immediate

module instDecoder (
  input  logic [rvExecPkg::xlen-1:0] instr,
  output rvExecPkg::ctrlT            ctrl,
  output logic [rvExecPkg::xlen-1:0] imm
);

  rvExecPkg::opcodeE opcode;
  logic [2:0]        funct3;

  assign opcode = rvExecPkg::opcodeE'(instr[rvExecPkg::opcodeW-1:0]);
  assign funct3 = instr[14:12];

  always_comb begin
    ctrl          = '0;
    ctrl.aluSrcA  = rvExecPkg::srcAReg;
    ctrl.aluSrcB  = rvExecPkg::srcBReg;
    ctrl.memSize  = rvExecPkg::sizeWord;
    ctrl.loadType = rvExecPkg::ldWord;
    case (opcode)
      rvExecPkg::opCompute: begin
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = rvExecPkg::wbAlu;
      end
      rvExecPkg::opICompute: begin
        if (funct3 == 3'b001 || funct3 == 3'b101)
          ctrl.immSel = rvExecPkg::immShI; // slli, srli, srai
        else
          ctrl.immSel = rvExecPkg::immI;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcB  = rvExecPkg::srcBImm;
        ctrl.wbSel    = rvExecPkg::wbAlu;
      end
      rvExecPkg::opLoad: begin
        ctrl.immSel   = rvExecPkg::immI;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcB  = rvExecPkg::srcBImm;
        ctrl.memRead  = 1'b1;
        ctrl.wbSel    = rvExecPkg::wbMem;
        ctrl.loadType = rvExecPkg::loadTypeE'(funct3);
        case (funct3)
          3'b000, 3'b100: ctrl.memSize = rvExecPkg::sizeByte; // lb, lbu
          3'b001, 3'b101: ctrl.memSize = rvExecPkg::sizeHalf; // lh, lhu
          3'b010:         ctrl.memSize = rvExecPkg::sizeWord;
          default:        ctrl.illegal = 1'b1;
        endcase
      end
      rvExecPkg::opStore: begin
        ctrl.immSel   = rvExecPkg::immS;
        ctrl.aluSrcB  = rvExecPkg::srcBImm;
        ctrl.memWrite = 1'b1;
        case (funct3)
          3'b000:  ctrl.memSize = rvExecPkg::sizeByte;
          3'b001:  ctrl.memSize = rvExecPkg::sizeHalf;
          3'b010:  ctrl.memSize = rvExecPkg::sizeWord;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      rvExecPkg::opBranch: begin
        ctrl.immSel  = rvExecPkg::immB;
        ctrl.aluSrcA = rvExecPkg::srcAPc; // alu forms the branch target
        ctrl.aluSrcB = rvExecPkg::srcBImm;
      end
      rvExecPkg::opJal: begin
        ctrl.immSel   = rvExecPkg::immJ;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcA  = rvExecPkg::srcAPc;
        ctrl.aluSrcB  = rvExecPkg::srcBImm;
        ctrl.wbSel    = rvExecPkg::wbPc4;
      end
      rvExecPkg::opJalr: begin
        ctrl.immSel   = rvExecPkg::immI;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcB  = rvExecPkg::srcBImm;
        ctrl.wbSel    = rvExecPkg::wbPc4;
      end
      rvExecPkg::opLui: begin
        ctrl.immSel   = rvExecPkg::immU;
        ctrl.regWrite = 1'b1;
        ctrl.wbSel    = rvExecPkg::wbImm; // alu result unused
      end
      rvExecPkg::opAuipc: begin
        ctrl.immSel   = rvExecPkg::immU;
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcA  = rvExecPkg::srcAPc;
        ctrl.aluSrcB  = rvExecPkg::srcBImm;
        ctrl.wbSel    = rvExecPkg::wbAlu;
      end
      default: ctrl.illegal = 1'b1; // unknown opcode
    endcase
  end

  always_comb begin
    case (ctrl.immSel)
      rvExecPkg::immI:   imm = {{20{instr[31]}}, instr[31:20]};
      rvExecPkg::immS:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rvExecPkg::immB:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rvExecPkg::immU:   imm = {instr[31:12], 12'b0};
      rvExecPkg::immJ:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      rvExecPkg::immShI: imm = {27'b0, instr[24:20]}; // zero-extended shamt
      default:           imm = '0;
    endcase
  end

endmodule

// File: hdl/intAlu.sv
// RV32I integer ALU
// register and immediate ops, plus plain add for addresses and targets

module intAlu (
  input  logic [rvExecPkg::xlen-1:0] instr,
  input  logic [rvExecPkg::xlen-1:0] opA,
  input  logic [rvExecPkg::xlen-1:0] opB,
  output logic [rvExecPkg::xlen-1:0] result,
  output logic                       illegal
);

  rvExecPkg::opcodeE opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [4:0]        shamt;
  logic              isCompute;
  logic              isImm;
  logic              altOk;
  logic              f7Bad;

  assign opcode    = rvExecPkg::opcodeE'(instr[rvExecPkg::opcodeW-1:0]);
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign shamt     = opB[4:0];
  assign isCompute = (opcode == rvExecPkg::opCompute);
  assign isImm     = (opcode == rvExecPkg::opICompute);

  // funct7 0100000 only exists for sub and sra
  assign altOk = (funct3 == 3'b000) || (funct3 == 3'b101);
  assign f7Bad = !((funct7 == 7'b0000000) || (funct7 == 7'b0100000 && altOk));

  always_comb begin
    result  = opA + opB; // default add covers addresses and targets
    illegal = 1'b0;
    if (isCompute || isImm) begin
      case (funct3)
        3'b000: if (isCompute && funct7[5]) result = opA - opB;
        3'b001: result = opA << shamt;
        3'b010: result = {31'b0, $signed(opA) < $signed(opB)};
        3'b011: result = {31'b0, opA < opB};
        3'b100: result = opA ^ opB;
        3'b101: begin
          if (funct7[5])
            result = $signed(opA) >>> shamt; // sra keeps the sign
          else
            result = opA >> shamt;
        end
        3'b110: result = opA | opB;
        default: result = opA & opB;
      endcase
      // immediate forms carry imm bits in funct7 except for shifts
      if (isCompute)
        illegal = f7Bad;
      else if (funct3 == 3'b001 || funct3 == 3'b101)
        illegal = f7Bad;
    end
  end

endmodule

// File: hdl/branchResolver.sv
// Branch resolver
// evaluates branch conditions, picks the next pc and checks target alignment

module branchResolver (
  input  logic [rvExecPkg::xlen-1:0] instr,
  input  logic [rvExecPkg::xlen-1:0] pc,
  input  logic [rvExecPkg::xlen-1:0] rs1Val,
  input  logic [rvExecPkg::xlen-1:0] rs2Val,
  input  logic [rvExecPkg::xlen-1:0] target,
  output logic [rvExecPkg::xlen-1:0] nextPc,
  output logic                       illegal,
  output logic                       misaligned
);

  rvExecPkg::opcodeE opcode;
  logic [2:0]        funct3;
  logic              taken;

  assign opcode = rvExecPkg::opcodeE'(instr[rvExecPkg::opcodeW-1:0]);
  assign funct3 = instr[14:12];

  always_comb begin
    taken   = 1'b0;
    illegal = 1'b0;
    if (opcode == rvExecPkg::opJal || opcode == rvExecPkg::opJalr) begin
      taken = 1'b1; // jumps always go
    end else if (opcode == rvExecPkg::opBranch) begin
      case (funct3)
        3'b000:  taken = (rs1Val == rs2Val);
        3'b001:  taken = (rs1Val != rs2Val);
        3'b100:  taken = ($signed(rs1Val) < $signed(rs2Val));
        3'b101:  taken = ($signed(rs1Val) >= $signed(rs2Val));
        3'b110:  taken = (rs1Val < rs2Val);
        3'b111:  taken = (rs1Val >= rs2Val);
        default: illegal = 1'b1; // 010 and 011 undefined
      endcase
    end
  end

  assign nextPc     = taken ? target : pc + rvExecPkg::pcStep;
  assign misaligned = taken && (target[1:0] != 2'b00);

endmodule

// File: hdl/execStage.sv
// RV32I execute stage behind a Wishbone classic slave
// one request in, one registered response out a cycle later with ack

module execStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 cyc,
  input  logic                 stb,
  input  rvExecPkg::execReqT   datIn,
  output logic                 ack,
  output rvExecPkg::execRespT  datOut
);

  rvExecPkg::ctrlT             ctrl;
  rvExecPkg::execRespT         resp;
  logic [rvExecPkg::xlen-1:0] imm;
  logic [rvExecPkg::xlen-1:0] opA;
  logic [rvExecPkg::xlen-1:0] opB;
  logic [rvExecPkg::xlen-1:0] aluResult;
  logic [rvExecPkg::xlen-1:0] nextPc;
  logic [rvExecPkg::xlen-1:0] pcPlus4;
  logic                       aluIllegal;
  logic                       brIllegal;
  logic                       brMisaligned;
  logic                       memMisaligned;
  logic                       halt;
  logic                       accept;

  instDecoder dec0 (
    .instr (datIn.instr),
    .ctrl  (ctrl),
    .imm   (imm)
  );

  assign opA = (ctrl.aluSrcA == rvExecPkg::srcAPc)  ? datIn.pc : datIn.rs1Val;
  assign opB = (ctrl.aluSrcB == rvExecPkg::srcBImm) ? imm      : datIn.rs2Val;

  intAlu alu0 (
    .instr   (datIn.instr),
    .opA     (opA),
    .opB     (opB),
    .result  (aluResult),
    .illegal (aluIllegal)
  );

  branchResolver br0 (
    .instr      (datIn.instr),
    .pc         (datIn.pc),
    .rs1Val     (datIn.rs1Val),
    .rs2Val     (datIn.rs2Val),
    .target     (aluResult), // jump and branch target from alu
    .nextPc     (nextPc),
    .illegal    (brIllegal),
    .misaligned (brMisaligned)
  );

  // bytes are never misaligned
  always_comb begin
    memMisaligned = 1'b0;
    if (ctrl.memRead || ctrl.memWrite) begin
      case (ctrl.memSize)
        rvExecPkg::sizeHalf: memMisaligned = aluResult[0];
        rvExecPkg::sizeWord: memMisaligned = (aluResult[1:0] != 2'b00);
        default:             memMisaligned = 1'b0;
      endcase
    end
  end

  assign halt    = ctrl.illegal | aluIllegal | brIllegal | brMisaligned | memMisaligned;
  assign pcPlus4 = datIn.pc + rvExecPkg::pcStep;

  always_comb begin
    case (ctrl.wbSel)
      rvExecPkg::wbPc4: resp.rdValue = pcPlus4;
      rvExecPkg::wbImm: resp.rdValue = imm;
      rvExecPkg::wbMem: resp.rdValue = '0; // load data is not fetched here
      default:          resp.rdValue = aluResult;
    endcase
    resp.rdWrite   = ctrl.regWrite & ~halt;
    resp.nextPc    = nextPc;
    resp.memAddr   = aluResult;
    resp.memRead   = ctrl.memRead;
    resp.memWrite  = ctrl.memWrite;
    resp.memSize   = ctrl.memSize;
    resp.loadType  = ctrl.loadType;
    resp.storeData = datIn.rs2Val;
    resp.halt      = halt;
  end

  assign accept = cyc & stb & ~ack; // ack high blocks a second accept

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ack    <= 1'b0;
      datOut <= '0;
    end else begin
      ack <= accept; // single-cycle ack
      if (accept)
        datOut <= resp;
    end
  end

endmodule

// File: verif/execStageTb.sv
// Testbench for the RV32I execute stage
// drives Wishbone requests and checks each response against a reference model

module execStageTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;

  // about 160 requests at 2 cycles each plus reset, wide margin
  localparam int maxCycles = 2000;

  logic                clk = 1'b0;
  logic                rstN;
  logic                cyc;
  logic                stb;
  rvExecPkg::execReqT  datIn;
  logic                ack;
  rvExecPkg::execRespT datOut;

  int errors   = 0;
  int checks   = 0;
  int cycles   = 0;
  int reqCount = 0;
  int ackCount = 0;

  execStage dut0 (
    .clk    (clk),
    .rstN   (rstN),
    .cyc    (cyc),
    .stb    (stb),
    .datIn  (datIn),
    .ack    (ack),
    .datOut (datOut)
  );

  always #50 clk = ~clk;

  always @(negedge clk) begin
    if (ack)
      ackCount++; // ack is stable mid-cycle
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("timeout: run did not finish within %0d cycles", maxCycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opReg};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [6:0] op);
    return {imm, 5'd1, f3, 5'd3, op};
  endfunction

  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [6:0] op);
    return {imm, 5'd3, op};
  endfunction

  function automatic logic [31:0] encJ(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, opJal};
  endfunction

  function automatic logic [31:0] randPc();
    return $urandom & 32'hffff_fffc; // word aligned
  endfunction

  function automatic rvExecPkg::execReqT mkReq(input logic [31:0] instr, input logic [31:0] pc,
                                               input logic [31:0] rs1, input logic [31:0] rs2);
    rvExecPkg::execReqT r;
    r.instr  = instr;
    r.pc     = pc;
    r.rs1Val = rs1;
    r.rs2Val = rs2;
    return r;
  endfunction

  // integer op by funct3, alt picks sub or sra
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic rvExecPkg::execRespT refExec(input rvExecPkg::execReqT r);
    rvExecPkg::execRespT e;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] uImm;
    logic [31:0] jImm;
    logic [31:0] pc4;
    logic [31:0] tgt;
    logic        taken;
    logic        bad;
    op   = r.instr[6:0];
    f3   = r.instr[14:12];
    f7   = r.instr[31:25];
    iImm = {{20{r.instr[31]}}, r.instr[31:20]};
    sImm = {{20{r.instr[31]}}, r.instr[31:25], r.instr[11:7]};
    bImm = {{19{r.instr[31]}}, r.instr[31], r.instr[7], r.instr[30:25], r.instr[11:8], 1'b0};
    uImm = {r.instr[31:12], 12'h000};
    jImm = {{11{r.instr[31]}}, r.instr[31], r.instr[19:12], r.instr[20], r.instr[30:21], 1'b0};
    pc4  = r.pc + 32'd4;
    e           = '0;
    e.nextPc    = pc4;
    e.storeData = r.rs2Val;
    e.memSize   = rvExecPkg::sizeWord;
    e.loadType  = rvExecPkg::ldWord;
    taken       = 1'b0;
    bad         = 1'b0;
    tgt         = 32'd0;
    case (op)
      opReg: begin
        bad       = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
        e.rdValue = aluRef(f3, f7[5], r.rs1Val, r.rs2Val);
        e.rdWrite = 1'b1;
      end
      opImm: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          bad       = !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b101));
          e.rdValue = aluRef(f3, f7[5], r.rs1Val, {27'd0, r.instr[24:20]});
        end else begin
          e.rdValue = aluRef(f3, 1'b0, r.rs1Val, iImm); // addi never subtracts
        end
        e.rdWrite = 1'b1;
      end
      opLoad: begin
        e.memAddr  = r.rs1Val + iImm;
        e.memRead  = 1'b1;
        e.rdWrite  = 1'b1;
        e.loadType = rvExecPkg::loadTypeE'(f3);
        case (f3)
          3'b000, 3'b100: e.memSize = rvExecPkg::sizeByte;
          3'b001, 3'b101: e.memSize = rvExecPkg::sizeHalf;
          3'b010:         e.memSize = rvExecPkg::sizeWord;
          default:        bad = 1'b1;
        endcase
      end
      opStore: begin
        e.memAddr  = r.rs1Val + sImm;
        e.memWrite = 1'b1;
        case (f3)
          3'b000:  e.memSize = rvExecPkg::sizeByte;
          3'b001:  e.memSize = rvExecPkg::sizeHalf;
          3'b010:  e.memSize = rvExecPkg::sizeWord;
          default: bad = 1'b1;
        endcase
      end
      opBranch: begin
        tgt = r.pc + bImm;
        case (f3)
          3'b000:  taken = (r.rs1Val == r.rs2Val);
          3'b001:  taken = (r.rs1Val != r.rs2Val);
          3'b100:  taken = ($signed(r.rs1Val) < $signed(r.rs2Val));
          3'b101:  taken = ($signed(r.rs1Val) >= $signed(r.rs2Val));
          3'b110:  taken = (r.rs1Val < r.rs2Val);
          3'b111:  taken = (r.rs1Val >= r.rs2Val);
          default: bad = 1'b1;
        endcase
      end
      opJal: begin
        tgt       = r.pc + jImm;
        taken     = 1'b1;
        e.rdValue = pc4;
        e.rdWrite = 1'b1;
      end
      opJalr: begin
        tgt       = r.rs1Val + iImm;
        taken     = 1'b1;
        e.rdValue = pc4;
        e.rdWrite = 1'b1;
      end
      opLui: begin
        e.rdValue = uImm;
        e.rdWrite = 1'b1;
      end
      opAuipc: begin
        e.rdValue = r.pc + uImm;
        e.rdWrite = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (taken) begin
      e.nextPc = tgt;
      if (tgt[1:0] != 2'b00)
        bad = 1'b1;
    end
    if (e.memRead || e.memWrite) begin
      if (e.memSize == rvExecPkg::sizeHalf && e.memAddr[0])
        bad = 1'b1;
      if (e.memSize == rvExecPkg::sizeWord && e.memAddr[1:0] != 2'b00)
        bad = 1'b1;
    end
    e.halt = bad;
    if (bad)
      e.rdWrite = 1'b0;
    return e;
  endfunction

  // called on a falling edge, returns on a falling edge with ack low again
  task automatic wbExec(input rvExecPkg::execReqT req, output rvExecPkg::execRespT resp,
                        output int lat);
    int n;
    resp  = '0;
    cyc   = 1'b1;
    stb   = 1'b1;
    datIn = req;
    reqCount++;
    @(negedge clk);
    n = 1;
    while (!ack && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      errors++;
      $display("ack did not arrive within 4 cycles of the request");
    end else begin
      resp = datOut;
    end
    cyc = 1'b0;
    stb = 1'b0;
    @(negedge clk);
    if (ack) begin
      errors++;
      $display("ack stayed high for more than one cycle");
    end
    lat = n;
  endtask

  task automatic runOne(input string name, input rvExecPkg::execReqT req, input bit chkRd,
                        input bit chkMem, output rvExecPkg::execRespT got);
    rvExecPkg::execRespT exp;
    int lat;
    exp = refExec(req);
    wbExec(req, got, lat);
    if (chkRd)
      checkEq({name, " rdValue"}, exp.rdValue, got.rdValue);
    checkEq({name, " rdWrite"}, 32'(exp.rdWrite), 32'(got.rdWrite));
    checkEq({name, " nextPc"}, exp.nextPc, got.nextPc);
    checkEq({name, " halt"}, 32'(exp.halt), 32'(got.halt));
    checkEq({name, " memRead"}, 32'(exp.memRead), 32'(got.memRead));
    checkEq({name, " memWrite"}, 32'(exp.memWrite), 32'(got.memWrite));
    checkEq({name, " storeData"}, exp.storeData, got.storeData);
    if (chkMem) begin
      checkEq({name, " memAddr"}, exp.memAddr, got.memAddr);
      checkEq({name, " memSize"}, 32'(exp.memSize), 32'(got.memSize));
      checkEq({name, " loadType"}, 32'(exp.loadType), 32'(got.loadType));
    end
  endtask

  task automatic testHandshake();
    rvExecPkg::execRespT got;
    rvExecPkg::execRespT exp;
    rvExecPkg::execReqT  req;
    logic [31:0] a;
    logic [31:0] prevRd;
    int lat;
    int n;
    checkEq("reset ack", 32'd0, 32'(ack));
    checkEq("reset datOut", 32'd0, 32'(datOut != '0));
    for (int rep = 0; rep < 3; rep++) begin
      a = $urandom;
      wbExec(mkReq(encI(12'h001, 3'b000, opImm), randPc(), a, 32'd0), got, lat);
      checkEq("handshake latency", 32'd1, lat);
      checkEq("handshake addi", a + 32'd1, got.rdValue);
    end
    // stb stays up and the next request follows in the ack cycle
    cyc = 1'b1;
    stb = 1'b1;
    for (int rep = 0; rep < 4; rep++) begin
      req   = mkReq(encR(7'h00, 3'b000), randPc(), $urandom, $urandom);
      exp   = refExec(req);
      datIn = req;
      reqCount++;
      @(negedge clk);
      n = 1;
      if (rep > 0)
        checkEq("back-to-back hold", prevRd, datOut.rdValue); // ack cycle blocks accept
      while (!ack && n < 4) begin
        @(negedge clk);
        n++;
      end
      checkEq("back-to-back latency", (rep == 0) ? 32'd1 : 32'd2, n);
      checkEq("back-to-back rdValue", exp.rdValue, datOut.rdValue);
      prevRd = datOut.rdValue;
    end
    cyc = 1'b0;
    stb = 1'b0;
    @(negedge clk);
    checkEq("back-to-back ack drop", 32'd0, 32'(ack));
  endtask

  task automatic testAluOps();
    rvExecPkg::execRespT got;
    logic [31:0] a;
    logic [11:0] imm;
    logic [2:0]  f3;
    for (int rep = 0; rep < 4; rep++) begin
      for (int k = 0; k < 10; k++) begin
        f3 = (k < 8) ? k[2:0] : ((k == 8) ? 3'b000 : 3'b101); // 8 is sub, 9 is sra
        a  = $urandom;
        if (k == 9 && rep < 2)
          a = a | 32'h8000_0000; // negative sra operand
        runOne($sformatf("reg f3=%0d alt=%0d", f3, k >= 8),
               mkReq(encR((k >= 8) ? 7'h20 : 7'h00, f3), randPc(), a, $urandom),
               1'b1, 1'b0, got);
      end
      for (int k = 0; k < 8; k++) begin
        imm = 12'($urandom);
        if (k == 1 || k == 5)
          imm = {7'h00, imm[4:0]}; // slli, srli
        runOne($sformatf("imm f3=%0d", k),
               mkReq(encI(imm, k[2:0], opImm), randPc(), $urandom, $urandom),
               1'b1, 1'b0, got);
      end
      runOne("srai", mkReq(encI({7'h20, 5'($urandom)}, 3'b101, opImm), randPc(),
             $urandom | 32'h8000_0000, $urandom), 1'b1, 1'b0, got);
    end
  endtask

  task automatic testBranches();
    rvExecPkg::execRespT got;
    logic [31:0] a;
    logic [31:0] b;
    logic [12:0] off;
    for (int k = 0; k < 8; k++) begin
      if (k == 2 || k == 3)
        continue;
      for (int p = 0; p < 4; p++) begin
        a = $urandom;
        b = a;
        if (p == 1) begin
          a = 32'd5;
          b = 32'd100;
        end else if (p == 2) begin
          a = 32'hffff_fff0; // signs differ
          b = 32'd5;
        end else if (p == 3) begin
          a = 32'd5;
          b = 32'hffff_fff0;
        end
        off = p[0] ? 13'h1fc0 : 13'h0040; // back 64 or forward 64
        runOne($sformatf("branch f3=%0d case=%0d", k, p),
               mkReq(encB(off, k[2:0]), randPc(), a, b), 1'b0, 1'b0, got);
      end
    end
    runOne("jal forward", mkReq(encJ(21'h000800), randPc(), $urandom, $urandom),
           1'b1, 1'b0, got);
    runOne("jal backward", mkReq(encJ(21'h1ffff0), randPc(), $urandom, $urandom),
           1'b1, 1'b0, got);
    runOne("jalr forward", mkReq(encI(12'h008, 3'b000, opJalr), randPc(), randPc(), $urandom),
           1'b1, 1'b0, got);
    runOne("jalr backward", mkReq(encI(12'hff8, 3'b000, opJalr), randPc(), randPc(), $urandom),
           1'b1, 1'b0, got);
  endtask

  task automatic testUpperImm();
    rvExecPkg::execRespT got;
    for (int rep = 0; rep < 4; rep++) begin
      runOne("lui", mkReq(encU(20'($urandom), opLui), randPc(), $urandom, $urandom),
             1'b1, 1'b0, got);
      runOne("auipc", mkReq(encU(20'($urandom), opAuipc), randPc(), $urandom, $urandom),
             1'b1, 1'b0, got);
    end
  endtask

  task automatic testLoadStore();
    rvExecPkg::execRespT got;
    for (int k = 0; k < 6; k++) begin
      if (k == 3)
        continue; // no load with funct3 011
      for (int ofs = 0; ofs < 4; ofs++)
        runOne($sformatf("load f3=%0d ofs=%0d", k, ofs),
               mkReq(encI(12'(ofs), k[2:0], opLoad), randPc(), randPc(), $urandom),
               1'b1, 1'b1, got);
    end
    for (int k = 0; k < 3; k++) begin
      for (int ofs = 0; ofs < 4; ofs++)
        runOne($sformatf("store f3=%0d ofs=%0d", k, ofs),
               mkReq(encS(12'(ofs), k[2:0]), randPc(), randPc(), $urandom),
               1'b0, 1'b1, got);
    end
    runOne("sw negative offset", mkReq(encS(12'hffe, 3'b010), randPc(), randPc(), $urandom),
           1'b0, 1'b1, got);
  endtask

  task automatic testIllegal();
    rvExecPkg::execRespT got;
    logic [31:0] instrs [7];
    instrs[0] = {25'($urandom), 7'b1111111};           // unknown opcode
    instrs[1] = encR(7'h01, 3'b000);                    // multiply encoding
    instrs[2] = encR(7'h20, 3'b100);
    instrs[3] = encI({7'h20, 5'd3}, 3'b001, opImm);
    instrs[4] = encB(13'h0040, 3'b010);
    instrs[5] = encJ(21'h000006);                       // target ends in 2'b10
    instrs[6] = encI(12'h000, 3'b011, opLoad);
    for (int k = 0; k < 7; k++) begin
      runOne($sformatf("illegal case=%0d", k),
             mkReq(instrs[k], randPc(), $urandom, $urandom), 1'b0, 1'b0, got);
      checkEq($sformatf("illegal case=%0d halt set", k), 32'd1, 32'(got.halt));
      checkEq($sformatf("illegal case=%0d rdWrite clear", k), 32'd0, 32'(got.rdWrite));
    end
  endtask

  initial begin
    void'($urandom(32'he6e01dba));
    rstN  = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    datIn = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testHandshake();
    testAluOps();
    testBranches();
    testUpperImm();
    testLoadStore();
    testIllegal();
    checkEq("ack count", reqCount, ackCount); // one ack per request
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: build.f
hdl/rvExecPkg.sv
hdl/instDecoder.sv
hdl/intAlu.sv
hdl/branchResolver.sv
hdl/execStage.sv
verif/execStageTb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execStageTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
